/* Makefile */
# Verilator build and run of the SRAM test chip testbench

VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = sram_test_tb
FILELIST  = src.f
OBJ_DIR   = obj_dir
PASS_MSG  = test passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* design/dual_port_sram.sv */
// Behavioral dual-port SRAM
// Port 0 reads and writes with a byte mask, port 1 only reads.
// Outputs are registered, read-first, and hold while the port is idle

`timescale 1ns/100ps

module dual_port_sram
   import sram_test_pkg::*;
#(
   parameter int  DEPTH  = 256,
   parameter type word_t = logic [31:0]
) (
   input  logic               clk,
   input  logic               csb0_i,
   input  logic               web0_i,
   input  logic [WMASK_W-1:0] wmask0_i,
   input  logic [ADDR_W-1:0]  addr0_i,
   input  logic [ADDR_W-1:0]  addr1_i,
   input  word_t              din0_i,
   input  logic               csb1_i,
   output word_t              dout0_o,
   output word_t              dout1_o
);

   localparam int NUM_BYTES = $bits(word_t) / 8;
   localparam int IDX_W     = $clog2(DEPTH);

   word_t             mem [DEPTH];
   logic [IDX_W-1:0]  idx0;
   logic [IDX_W-1:0]  idx1;

   // Depth is a power of two, so dropping the upper bits is the modulo
   assign idx0 = addr0_i[IDX_W-1:0];
   assign idx1 = addr1_i[IDX_W-1:0];

   // Port 0, old word is read out in the same cycle as a write
   always_ff @(posedge clk) begin
      if (!csb0_i) begin
         if (!web0_i) begin
            for (int b = 0; b < NUM_BYTES; b++) begin
               if (wmask0_i[b]) begin
                  mem[idx0][b*8 +: 8] <= din0_i[b*8 +: 8];
               end
            end
         end
         dout0_o <= mem[idx0];
      end
   end

   // Port 1
   always_ff @(posedge clk) begin
      if (!csb1_i) begin
         dout1_o <= mem[idx1];
      end
   end

endmodule

/* design/result_capture.sv */
// Read data capture
// Registers both outputs of every chip each cycle and selects the
// pair of the chip addressed by the current command

`timescale 1ns/100ps

module result_capture
   import sram_test_pkg::*;
(
   input  logic  clk,
   input  logic  rstn,
   input  chip_t chip_i,
   input  data_t dout0_i [NUM_CHIPS],
   input  data_t dout1_i [NUM_CHIPS],
   output data_t rd0_o,
   output data_t rd1_o
);

   data_t data0_q [NUM_CHIPS];
   data_t data1_q [NUM_CHIPS];

   // Free-running capture, one cycle behind the SRAM outputs
   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 0; i < NUM_CHIPS; i++) begin
            data0_q[i] <= '0;
            data1_q[i] <= '0;
         end
      end else begin
         for (int i = 0; i < NUM_CHIPS; i++) begin
            data0_q[i] <= dout0_i[i];
            data1_q[i] <= dout1_i[i];
         end
      end
   end

   // Chip field follows the command register, so the pair can change on reload
   assign rd0_o = data0_q[chip_i];
   assign rd1_o = data1_q[chip_i];

endmodule

/* design/scan_decode.sv */
// Command register and decoder
// Loads the 64-bit command by scan, LA lines or captured SRAM data,
// and turns its fields into per-chip SRAM port controls

`timescale 1ns/100ps

module scan_decode
   import sram_test_pkg::*;
(
   input  logic              clk,
   input  logic              rstn,
   input  logic              scan_en_i,
   input  logic              scan_in_i,
   input  logic              la_load_i,
   input  logic              sram_load_i,
   input  logic              global_csb_i,
   input  logic [SCAN_W-1:0] la_data_i,
   input  data_t             rd0_i,
   input  data_t             rd1_i,
   output logic              scan_out_o,
   output logic [SCAN_W-1:0] la_data_o,
   output chip_t             chip_o,
   sram_port_if.ctrl         port
);

   logic [SCAN_W-1:0]  cmd_q;

   // Decoded fields
   chip_t              chip;
   logic               en0;
   logic               we0;
   logic               en1;
   logic [WMASK_W-1:0] wmask0;
   logic [ADDR_W-1:0]  addr0;
   logic [ADDR_W-1:0]  addr1;
   data_t              din0;

   // LA load wins over result load, result load over scan shift
   always_ff @(posedge clk) begin
      if (!rstn) begin
         cmd_q <= '0;
      end else if (la_load_i) begin
         cmd_q <= la_data_i;
      end else if (sram_load_i) begin
         cmd_q <= {rd0_i, rd1_i};
      end else if (scan_en_i) begin
         cmd_q <= {cmd_q[SCAN_W-2:0], scan_in_i};
      end
   end

   assign scan_out_o = cmd_q[SCAN_W-1];
   assign la_data_o  = cmd_q;

   // Field split
   assign chip   = cmd_q[CHIP_LSB +: CHIP_W];
   assign en0    = cmd_q[EN0_LSB];
   assign we0    = cmd_q[WE0_LSB];
   assign wmask0 = cmd_q[WMASK_LSB +: WMASK_W];
   assign addr0  = cmd_q[ADDR0_LSB +: ADDR_W];
   assign din0   = cmd_q[DIN0_LSB +: DATA_W];
   assign en1    = cmd_q[EN1_LSB];
   assign addr1  = cmd_q[ADDR1_LSB +: ADDR_W];

   assign chip_o      = chip;
   assign port.web0   = ~we0;
   assign port.wmask0 = wmask0;
   assign port.addr0  = addr0;
   assign port.din0   = din0;
   assign port.addr1  = addr1;

   // Only the addressed chip is selected, and only while the global strobe is low
   always_comb begin
      for (int i = 0; i < NUM_CHIPS; i++) begin
         port.csb0[i] = ~(~global_csb_i & en0 & (chip == chip_t'(i)));
         port.csb1[i] = ~(~global_csb_i & en1 & (chip == chip_t'(i)));
      end
   end

endmodule

/* design/sram_bank.sv */
// SRAM bank
// Four dual-port SRAMs of different geometry sharing one port bundle.
// Chip 0 is byte wide and its outputs are zero-extended

`timescale 1ns/100ps

module sram_bank
   import sram_test_pkg::*;
(
   input  logic        clk,
   sram_port_if.mem    port,
   output data_t       dout0_o [NUM_CHIPS],
   output data_t       dout1_o [NUM_CHIPS]
);

   byte_word_t chip0_dout0;
   byte_word_t chip0_dout1;

   // 8-bit chip, takes the low byte of the write data
   dual_port_sram #(
      .DEPTH  (CHIP_DEPTH[0]),
      .word_t (byte_word_t)
   ) u_sram0 (
      .clk      (clk),
      .csb0_i   (port.csb0[0]),
      .web0_i   (port.web0),
      .wmask0_i (port.wmask0),
      .addr0_i  (port.addr0),
      .addr1_i  (port.addr1),
      .din0_i   (port.din0[7:0]),
      .csb1_i   (port.csb1[0]),
      .dout0_o  (chip0_dout0),
      .dout1_o  (chip0_dout1)
   );

   assign dout0_o[0] = data_t'(chip0_dout0);
   assign dout1_o[0] = data_t'(chip0_dout1);

   // Full-width chips
   for (genvar i = 1; i < NUM_CHIPS; i++) begin : g_chip
      dual_port_sram #(
         .DEPTH  (CHIP_DEPTH[i]),
         .word_t (data_t)
      ) u_sram (
         .clk      (clk),
         .csb0_i   (port.csb0[i]),
         .web0_i   (port.web0),
         .wmask0_i (port.wmask0),
         .addr0_i  (port.addr0),
         .addr1_i  (port.addr1),
         .din0_i   (port.din0),
         .csb1_i   (port.csb1[i]),
         .dout0_o  (dout0_o[i]),
         .dout1_o  (dout1_o[i])
      );
   end

endmodule

/* design/sram_port_if.sv */
// SRAM port bundle
// Shared port-0/port-1 controls from the command decoder to the SRAM bank

`timescale 1ns/100ps

interface sram_port_if
   import sram_test_pkg::*;
();

   // One active-low select per chip and port
   logic [NUM_CHIPS-1:0] csb0;
   logic [NUM_CHIPS-1:0] csb1;

   // Port 0 is read/write, web0 active low
   logic                 web0;
   logic [WMASK_W-1:0]   wmask0;
   logic [ADDR_W-1:0]    addr0;
   data_t                din0;

   // Port 1 is read only
   logic [ADDR_W-1:0]    addr1;

   modport ctrl (output csb0, csb1, web0, wmask0, addr0, din0, addr1);
   modport mem  (input  csb0, csb1, web0, wmask0, addr0, din0, addr1);

endinterface

/* design/sram_test_pkg.sv */
// SRAM test chip package
// Widths, command register field positions, chip geometry and word types

package sram_test_pkg;

   // Bank geometry
   localparam int NUM_CHIPS = 4;
   localparam int CHIP_W    = 2;
   localparam int ADDR_W    = 10;
   localparam int DATA_W    = 32;
   localparam int WMASK_W   = 4;
   localparam int SCAN_W    = 64;

   // Command register fields, low bit of each
   // Bits 63..61 are spare
   localparam int CHIP_LSB  = 59;
   localparam int EN0_LSB   = 58;
   localparam int WE0_LSB   = 57;
   localparam int WMASK_LSB = 53;
   localparam int ADDR0_LSB = 43;
   localparam int DIN0_LSB  = 11;
   localparam int EN1_LSB   = 10;
   localparam int ADDR1_LSB = 0;

   // Word depth of each chip, all powers of two
   localparam int CHIP_DEPTH [NUM_CHIPS] = '{256, 256, 512, 1024};

   // Full data word
   typedef logic [DATA_W-1:0] data_t;

   // Narrow word of chip 0
   typedef logic [7:0] byte_word_t;

   // Chip number
   typedef logic [CHIP_W-1:0] chip_t;

endpackage

/* design/sram_test_top.sv */
// SRAM test chip top level
// Command register and decoder, SRAM bank and read data capture

`timescale 1ns/100ps

module sram_test_top
   import sram_test_pkg::*;
(
   input  logic              clk,
   input  logic              rstn,
   input  logic              scan_en_i,
   input  logic              scan_in_i,
   output logic              scan_out_o,
   input  logic              la_load_i,
   input  logic [SCAN_W-1:0] la_data_i,
   output logic [SCAN_W-1:0] la_data_o,
   input  logic              sram_load_i,
   input  logic              global_csb_i
);

   chip_t chip;
   data_t rd0;
   data_t rd1;
   data_t dout0 [NUM_CHIPS];
   data_t dout1 [NUM_CHIPS];

   sram_port_if port_if ();

   scan_decode u_decode (
      .clk          (clk),
      .rstn         (rstn),
      .scan_en_i    (scan_en_i),
      .scan_in_i    (scan_in_i),
      .la_load_i    (la_load_i),
      .sram_load_i  (sram_load_i),
      .global_csb_i (global_csb_i),
      .la_data_i    (la_data_i),
      .rd0_i        (rd0),
      .rd1_i        (rd1),
      .scan_out_o   (scan_out_o),
      .la_data_o    (la_data_o),
      .chip_o       (chip),
      .port         (port_if.ctrl)
   );

   sram_bank u_bank (
      .clk     (clk),
      .port    (port_if.mem),
      .dout0_o (dout0),
      .dout1_o (dout1)
   );

   result_capture u_capture (
      .clk     (clk),
      .rstn    (rstn),
      .chip_i  (chip),
      .dout0_i (dout0),
      .dout1_i (dout1),
      .rd0_o   (rd0),
      .rd1_o   (rd1)
   );

endmodule

/* src.f */
design/sram_test_pkg.sv
design/sram_port_if.sv
design/scan_decode.sv
design/dual_port_sram.sv
design/sram_bank.sv
design/result_capture.sv
design/sram_test_top.sv
verification/clk_gen.sv
verification/sram_test_tb.sv

/* verification/clk_gen.sv */
// Testbench clock and reset generator
// Free-running clock, reset held low for a fixed number of cycles

`timescale 1ns/100ps

module clk_gen #(
   parameter int HALF_PERIOD  = 4,
   parameter int RESET_CYCLES = 8
) (
   output logic clk,
   output logic rstn
);

   initial begin
      clk = 1'b0;
      forever #(HALF_PERIOD) clk = ~clk;
   end

   // Released on a falling edge, away from the sampling edge
   initial begin
      rstn = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rstn = 1'b1;
   end

endmodule

/* verification/sram_test_tb.sv */
// SRAM test chip testbench
// Applies a table of scan and LA commands, then random write/read pairs,
// and checks the loaded-back results against a reference memory model

`timescale 1ns/100ps

module sram_test_tb
   import sram_test_pkg::*;
();

   localparam int NUM_OPS       = 23;
   localparam int NUM_RANDOM    = 8;
   localparam int RESET_TIMEOUT = 50;
   localparam int LOAD_TIMEOUT  = 8;

   typedef struct packed {
      logic        use_scan;
      logic        strobe;
      logic [1:0]  chip;
      logic        en0;
      logic        we;
      logic [3:0]  mask;
      logic [9:0]  addr0;
      logic [31:0] din0;
      logic        en1;
      logic [9:0]  addr1;
   } op_t;

   logic              clk;
   logic              rstn;
   logic              scan_en_i;
   logic              scan_in_i;
   logic              scan_out_o;
   logic              la_load_i;
   logic [SCAN_W-1:0] la_data_i;
   logic [SCAN_W-1:0] la_data_o;
   logic              sram_load_i;
   logic              global_csb_i;

   // Reference model state
   logic [31:0] ref_mem  [NUM_CHIPS][1024];
   bit          ref_set  [NUM_CHIPS][1024];
   data_t       hold0    [NUM_CHIPS];
   data_t       hold1    [NUM_CHIPS];
   bit          hold0_ok [NUM_CHIPS];
   bit          hold1_ok [NUM_CHIPS];

   logic [31:0] seed    = 32'hdf9d3469;

   // scan, strobe, chip, en0, we, mask, addr0, din0, en1, addr1
   op_t ops [NUM_OPS] = '{
      '{1'b1, 1'b1, 2'd0, 1'b1, 1'b1, 4'hf, 10'h010, 32'h12345678, 1'b0, 10'h000},
      '{1'b1, 1'b1, 2'd1, 1'b1, 1'b1, 4'hf, 10'h020, 32'hdeadbeef, 1'b0, 10'h000},
      '{1'b0, 1'b1, 2'd2, 1'b1, 1'b1, 4'hf, 10'h1f0, 32'hcafef00d, 1'b0, 10'h000},
      '{1'b0, 1'b1, 2'd3, 1'b1, 1'b1, 4'hf, 10'h3ff, 32'h0badc0de, 1'b0, 10'h000},
      '{1'b1, 1'b1, 2'd0, 1'b1, 1'b0, 4'h0, 10'h010, 32'h00000000, 1'b1, 10'h010},
      '{1'b1, 1'b1, 2'd1, 1'b1, 1'b0, 4'h0, 10'h020, 32'h00000000, 1'b1, 10'h020},
      '{1'b1, 1'b1, 2'd2, 1'b1, 1'b0, 4'h0, 10'h1f0, 32'h00000000, 1'b1, 10'h1f0},
      '{1'b1, 1'b1, 2'd3, 1'b1, 1'b0, 4'h0, 10'h3ff, 32'h00000000, 1'b1, 10'h3ff},
      '{1'b0, 1'b1, 2'd1, 1'b1, 1'b1, 4'h5, 10'h020, 32'h11223344, 1'b0, 10'h000},
      '{1'b0, 1'b1, 2'd1, 1'b1, 1'b0, 4'h0, 10'h020, 32'h00000000, 1'b0, 10'h000},
      '{1'b0, 1'b1, 2'd0, 1'b1, 1'b1, 4'he, 10'h010, 32'haabbccdd, 1'b0, 10'h000},
      '{1'b0, 1'b1, 2'd0, 1'b1, 1'b1, 4'h1, 10'h010, 32'haabbccdd, 1'b0, 10'h000},
      '{1'b0, 1'b1, 2'd0, 1'b1, 1'b0, 4'h0, 10'h010, 32'h00000000, 1'b1, 10'h010},
      '{1'b1, 1'b1, 2'd2, 1'b1, 1'b1, 4'hf, 10'h1f0, 32'h55aa55aa, 1'b1, 10'h1f0},
      '{1'b1, 1'b1, 2'd2, 1'b1, 1'b0, 4'h0, 10'h1f0, 32'h00000000, 1'b1, 10'h1f0},
      '{1'b0, 1'b1, 2'd0, 1'b1, 1'b1, 4'hf, 10'h110, 32'h00000042, 1'b0, 10'h000},
      '{1'b0, 1'b1, 2'd0, 1'b1, 1'b0, 4'h0, 10'h010, 32'h00000000, 1'b1, 10'h210},
      '{1'b0, 1'b1, 2'd2, 1'b1, 1'b1, 4'hf, 10'h3f0, 32'h13572468, 1'b0, 10'h000},
      '{1'b1, 1'b1, 2'd2, 1'b1, 1'b0, 4'h0, 10'h1f0, 32'h00000000, 1'b1, 10'h3f0},
      '{1'b0, 1'b1, 2'd1, 1'b1, 1'b0, 4'h0, 10'h120, 32'h00000000, 1'b1, 10'h320},
      '{1'b0, 1'b0, 2'd3, 1'b1, 1'b1, 4'hf, 10'h3ff, 32'hffffffff, 1'b1, 10'h3ff},
      '{1'b0, 1'b1, 2'd3, 1'b0, 1'b1, 4'hf, 10'h3ff, 32'h11111111, 1'b0, 10'h000},
      '{1'b1, 1'b1, 2'd3, 1'b1, 1'b0, 4'h0, 10'h3ff, 32'h00000000, 1'b1, 10'h3ff}
   };

   clk_gen u_clk_gen (
      .clk  (clk),
      .rstn (rstn)
   );

   sram_test_top dut0 (
      .clk          (clk),
      .rstn         (rstn),
      .scan_en_i    (scan_en_i),
      .scan_in_i    (scan_in_i),
      .scan_out_o   (scan_out_o),
      .la_load_i    (la_load_i),
      .la_data_i    (la_data_i),
      .la_data_o    (la_data_o),
      .sram_load_i  (sram_load_i),
      .global_csb_i (global_csb_i)
   );

   function automatic logic [31:0] next_random();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   task automatic abort_run();
      $display("test failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
      if (actual !== expected) begin
         $display("FAIL %s: got %h, expected %h", name, actual, expected);
         abort_run();
      end
   endtask

   task automatic wait_for_cmd(input logic [63:0] cmd);
      int n;
      n = 0;
      while (la_data_o !== cmd) begin
         if (n == LOAD_TIMEOUT) begin
            $display("Command register did not take the new command in time");
            abort_run();
         end
         n++;
         @(negedge clk);
      end
   endtask

   task automatic scan_in_word(input logic [63:0] cmd);
      for (int i = SCAN_W - 1; i >= 0; i--) begin
         @(negedge clk);
         scan_en_i = 1'b1;
         scan_in_i = cmd[i];
      end
      @(negedge clk);
      scan_en_i = 1'b0;
   endtask

   task automatic la_load_word(input logic [63:0] cmd);
      @(negedge clk);
      la_data_i = cmd;
      la_load_i = 1'b1;
      @(negedge clk);
      la_load_i = 1'b0;
   endtask

   // Starts on a falling edge and shifts MSB first with zeros behind
   task automatic scan_out_word(output logic [63:0] w);
      for (int i = 0; i < SCAN_W; i++) begin
         w = {w[62:0], scan_out_o};
         scan_en_i = 1'b1;
         scan_in_i = 1'b0;
         @(negedge clk);
      end
      scan_en_i = 1'b0;
   endtask

   // Both ports see the old word before the masked write lands
   task automatic model_access(input op_t op);
      int c;
      int idx0;
      int idx1;
      c    = int'(op.chip);
      idx0 = int'(op.addr0) % CHIP_DEPTH[c];
      idx1 = int'(op.addr1) % CHIP_DEPTH[c];
      if (op.strobe && op.en1) begin
         hold1[c]    = ref_mem[c][idx1];
         hold1_ok[c] = ref_set[c][idx1];
      end
      if (op.strobe && op.en0) begin
         hold0[c]    = ref_mem[c][idx0];
         hold0_ok[c] = ref_set[c][idx0];
         if (op.we) begin
            // Chip 0 only has the low byte
            for (int b = 0; b < 4; b++) begin
               if (op.mask[b] && (c != 0 || b == 0)) begin
                  ref_mem[c][idx0][b*8 +: 8] = op.din0[b*8 +: 8];
               end
            end
            if ((c == 0) ? op.mask[0] : (op.mask == 4'hf)) begin
               ref_set[c][idx0] = 1'b1;
            end
         end
      end
   endtask

   task automatic run_op(input op_t op);
      logic [63:0] cmd;
      logic [63:0] result;
      int          c;
      c   = int'(op.chip);
      cmd = '0;
      cmd[CHIP_LSB +: CHIP_W]   = op.chip;
      cmd[EN0_LSB]              = op.en0;
      cmd[WE0_LSB]              = op.we;
      cmd[WMASK_LSB +: WMASK_W] = op.mask;
      cmd[ADDR0_LSB +: ADDR_W]  = op.addr0;
      cmd[DIN0_LSB +: DATA_W]   = op.din0;
      cmd[EN1_LSB]              = op.en1;
      cmd[ADDR1_LSB +: ADDR_W]  = op.addr1;
      if (op.use_scan) begin
         scan_in_word(cmd);
      end else begin
         la_load_word(cmd);
      end
      wait_for_cmd(cmd);
      // One-cycle access strobe
      global_csb_i = ~op.strobe;
      @(negedge clk);
      global_csb_i = 1'b1;
      model_access(op);
      // SRAM output comes one edge after the access and the capture one edge later
      @(negedge clk);
      sram_load_i = 1'b1;
      @(negedge clk);
      sram_load_i = 1'b0;
      if (op.use_scan) begin
         scan_out_word(result);
      end else begin
         result = la_data_o;
      end
      if (hold0_ok[c]) begin
         check_value("rd0 (result bits 63..32)", {32'h0, result[63:32]}, {32'h0, hold0[c]});
      end
      if (hold1_ok[c]) begin
         check_value("rd1 (result bits 31..0)", {32'h0, result[31:0]}, {32'h0, hold1[c]});
      end
   endtask

   initial begin
      logic [63:0] w;
      logic [31:0] r;
      op_t         wr_op;
      op_t         rd_op;
      int          n;
      scan_en_i    = 1'b0;
      scan_in_i    = 1'b0;
      la_load_i    = 1'b0;
      la_data_i    = '0;
      sram_load_i  = 1'b0;
      global_csb_i = 1'b1;
      for (int c = 0; c < NUM_CHIPS; c++) begin
         for (int a = 0; a < 1024; a++) begin
            ref_mem[c][a] = '0;
         end
      end

      n = 0;
      while (rstn !== 1'b1) begin
         if (n == RESET_TIMEOUT) begin
            $display("Reset was never released");
            abort_run();
         end
         n++;
         @(negedge clk);
      end

      check_value("la_data_o", la_data_o, 64'h0);
      scan_out_word(w);
      check_value("scan_out_o", w, 64'h0);

      for (int i = 0; i < NUM_OPS; i++) begin
         run_op(ops[i]);
      end

      // Random write followed by a read back through an alias of the same word
      for (int k = 0; k < NUM_RANDOM; k++) begin
         r = next_random();
         wr_op.use_scan = r[12];
         wr_op.strobe   = 1'b1;
         wr_op.chip     = r[1:0];
         wr_op.en0      = 1'b1;
         wr_op.we       = 1'b1;
         wr_op.mask     = 4'hf;
         wr_op.addr0    = r[11:2];
         wr_op.din0     = next_random();
         wr_op.en1      = 1'b0;
         wr_op.addr1    = '0;
         run_op(wr_op);
         rd_op          = wr_op;
         rd_op.use_scan = r[13];
         rd_op.we       = 1'b0;
         rd_op.addr0    = wr_op.addr0 ^ ADDR_W'(CHIP_DEPTH[int'(wr_op.chip)]);
         rd_op.en1      = 1'b1;
         rd_op.addr1    = wr_op.addr0;
         run_op(rd_op);
      end

      $display("test passed");
      $finish;
   end

endmodule
